// File: source/ghtPkg.sv
// global history table package: table sizes, index types,
// update port and bank write structs, index field helpers
package ghtPkg;

    localparam int NUM_BANKS = 8;
    localparam int NUM_ROWS = 32;
    localparam int ROW_BITS = 256;
    localparam int INIT_CYCLES = 32;

    typedef logic [15:0] addrT;
    typedef logic [15:0] histT;
    typedef logic [15:0] indexT;
    typedef logic [2:0] bankT;
    typedef logic [4:0] rowT;
    typedef logic [7:0] bitSelT;
    typedef logic [ROW_BITS-1:0] rowDataT;

    // one update port
    typedef struct packed {
        logic wen;
        indexT idx;
        logic val;
    } updateT;

    // write command for a single bank, already split into row and bit
    typedef struct packed {
        logic wen;
        rowT row;
        bitSelT bitSel;
        logic val;
    } bankWriteT;

    // bank from index bits 7:6 and 0
    function automatic bankT bankOf(indexT idx);
        return {idx[7:6], idx[0]};
    endfunction

    function automatic rowT rowOf(indexT idx);
        return idx[5:1];
    endfunction

    function automatic bitSelT bitOf(indexT idx);
        return idx[15:8];
    endfunction

endpackage

// File: source/ghtInit.sv
// post-reset sweep counter that clears the table row by row
`timescale 1ns/1ps

module ghtInit (
    input  logic clk,
    input  logic rst,
    output logic init,
    output ghtPkg::rowT initRow,
    output logic initDone
);

    always_ff @(posedge clk) begin
        if (rst) begin
            init <= 1'b1;
            initRow <= '0;
        end else if (init) begin
            // last row cleared this cycle
            if (initRow == ghtPkg::rowT'(ghtPkg::INIT_CYCLES - 1)) begin
                init <= 1'b0;
            end else begin
                initRow <= initRow + 1'b1;
            end
        end
    end

    assign initDone = ~init;

    // sweep counter parks once the table is clear
    initRowParked: assert property (@(posedge clk) disable iff (rst)
        !init |=> $stable(initRow) && !init);

endmodule

// File: source/ghtWriteArbiter.sv
// routes two update ports onto eight banks with a one-entry
// deferral buffer for bank conflicts and drop reporting
`timescale 1ns/1ps

module ghtWriteArbiter (
    input  logic clk,
    input  logic rst,
    input  logic init,
    input  ghtPkg::updateT upd0,
    input  ghtPkg::updateT upd1,
    output ghtPkg::bankWriteT [ghtPkg::NUM_BANKS-1:0] bankWrite,
    output logic dropped
);

    logic bufValid;
    ghtPkg::updateT bufReq;

    ghtPkg::bankT bank0;
    ghtPkg::bankT bank1;
    ghtPkg::bankT bankS;

    logic req0;
    logic req1;
    logic serveS;
    logic serve0;
    logic serve1;
    logic save0;
    logic save1;

    function automatic ghtPkg::bankWriteT toBankWrite(ghtPkg::updateT u);
        ghtPkg::bankWriteT w;
        w.wen = 1'b1;
        w.row = ghtPkg::rowOf(u.idx);
        w.bitSel = ghtPkg::bitOf(u.idx);
        w.val = u.val;
        return w;
    endfunction

    assign bank0 = ghtPkg::bankOf(upd0.idx);
    assign bank1 = ghtPkg::bankOf(upd1.idx);
    assign bankS = ghtPkg::bankOf(bufReq.idx);

    // ports are ignored during the clear sweep
    assign req0 = upd0.wen & ~init;
    assign req1 = upd1.wen & ~init;

    always_comb begin
        serveS = 1'b0;
        serve0 = 1'b0;
        serve1 = 1'b0;
        save0 = 1'b0;
        save1 = 1'b0;
        dropped = 1'b0;
        if (!bufValid || init) begin
            serve0 = req0;
            serve1 = req1 & (!req0 || bank1 != bank0);
            save1 = req1 & req0 & (bank1 == bank0);
        end else begin
            serveS = 1'b1;
            if (req0 && bank0 == bankS) begin
                // upd0 waits behind the buffered entry, upd1 has no place left
                save0 = 1'b1;
                serve1 = req1 & (bank1 != bankS);
                dropped = req1 & (bank1 == bankS);
            end else begin
                serve0 = req0;
                serve1 = req1 & (bank1 != bankS) & (!req0 || bank1 != bank0);
                save1 = req1 & ~serve1;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < ghtPkg::NUM_BANKS; k++) begin
            bankWrite[k] = '0;
            if (serveS && bankS == ghtPkg::bankT'(k)) begin
                bankWrite[k] = toBankWrite(bufReq);
            end else if (serve0 && bank0 == ghtPkg::bankT'(k)) begin
                bankWrite[k] = toBankWrite(upd0);
            end else if (serve1 && bank1 == ghtPkg::bankT'(k)) begin
                bankWrite[k] = toBankWrite(upd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bufValid <= 1'b0;
        end else begin
            bufValid <= save0 | save1;
        end
    end

    always_ff @(posedge clk) begin
        if (save1) begin
            bufReq <= upd1;
        end else if (save0) begin
            bufReq <= upd0;
        end
    end

    // no two granted requests share a bank
    oneWritePerBank: assert property (@(posedge clk) disable iff (rst)
        !(serveS && serve0 && bankS == bank0) &&
        !(serveS && serve1 && bankS == bank1) &&
        !(serve0 && serve1 && bank0 == bank1));

    noBufferDuringInit: assert property (@(posedge clk) disable iff (rst)
        init |=> !bufValid);

endmodule

// File: source/ghtBank.sv
// one table bank: 32 rows of 256 one-bit entries with
// single-bit writes, row clear and combinational bit read
`timescale 1ns/1ps

module ghtBank (
    input  logic clk,
    input  logic init,
    input  ghtPkg::rowT initRow,
    input  ghtPkg::bankWriteT bankWrite,
    input  ghtPkg::rowT readRow,
    input  ghtPkg::bitSelT readBit,
    output logic readVal
);

    ghtPkg::rowDataT rows [ghtPkg::NUM_ROWS];

    always_ff @(posedge clk) begin
        if (init) begin
            rows[initRow] <= '0;
        end else if (bankWrite.wen) begin
            // only the addressed entry changes
            rows[bankWrite.row][bankWrite.bitSel] <= bankWrite.val;
        end
    end

    assign readVal = rows[readRow][readBit];

endmodule

// File: source/ghtLookup.sv
// lookup stage: captures address and history, hashes the index
// and picks the prediction bit from the addressed bank
`timescale 1ns/1ps

module ghtLookup (
    input  logic clk,
    input  logic rst,
    input  logic init,
    input  logic readEn,
    input  ghtPkg::addrT addr,
    input  ghtPkg::histT hist,
    output ghtPkg::rowT readRow,
    output ghtPkg::bitSelT readBit,
    input  logic [ghtPkg::NUM_BANKS-1:0] bankBits,
    output logic pred,
    output logic predValid
);

    ghtPkg::addrT addrQ;
    ghtPkg::histT histQ;
    ghtPkg::indexT idx;

    always_ff @(posedge clk) begin
        if (readEn && !init) begin
            addrQ <= addr;
            histQ <= hist;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else begin
            predValid <= readEn & ~init;
        end
    end

    // hashed index
    assign idx = addrQ ^ histQ;

    assign readRow = ghtPkg::rowOf(idx);
    assign readBit = ghtPkg::bitOf(idx);
    assign pred = bankBits[ghtPkg::bankOf(idx)];

endmodule

// File: source/ghtTop.sv
// global history table top: init sweep, write arbiter,
// lookup stage and the eight banks
`timescale 1ns/1ps

module ghtTop (
    input  logic clk,
    input  logic rst,
    input  logic readEn,
    input  ghtPkg::addrT addr,
    input  ghtPkg::histT hist,
    input  ghtPkg::updateT upd0,
    input  ghtPkg::updateT upd1,
    output logic pred,
    output logic predValid,
    output logic dropped,
    output logic initDone
);

    logic init;
    ghtPkg::rowT initRow;
    ghtPkg::bankWriteT [ghtPkg::NUM_BANKS-1:0] bankWrite;
    ghtPkg::rowT readRow;
    ghtPkg::bitSelT readBit;
    logic [ghtPkg::NUM_BANKS-1:0] bankBits;

    ghtInit initUnit (
        .clk(clk),
        .rst(rst),
        .init(init),
        .initRow(initRow),
        .initDone(initDone)
    );

    ghtWriteArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .init(init),
        .upd0(upd0),
        .upd1(upd1),
        .bankWrite(bankWrite),
        .dropped(dropped)
    );

    ghtLookup lookup (
        .clk(clk),
        .rst(rst),
        .init(init),
        .readEn(readEn),
        .addr(addr),
        .hist(hist),
        .readRow(readRow),
        .readBit(readBit),
        .bankBits(bankBits),
        .pred(pred),
        .predValid(predValid)
    );

    // bank number is the position in this array
    for (genvar k = 0; k < ghtPkg::NUM_BANKS; k++) begin : banks
        ghtBank bank (
            .clk(clk),
            .init(init),
            .initRow(initRow),
            .bankWrite(bankWrite[k]),
            .readRow(readRow),
            .readBit(readBit),
            .readVal(bankBits[k])
        );
    end

endmodule

// File: tests/ghtChecker.sv
// checker: compares DUT outputs with expected values each cycle,
// times the clear sweep and counts errors
`timescale 1ns/1ps

module ghtChecker (
    input  logic clk,
    input  logic rst,
    input  logic pred,
    input  logic predValid,
    input  logic dropped,
    input  logic initDone,
    input  logic expValid,
    input  logic expPred,
    input  logic expDrop,
    input  logic modelDrop,
    output int predErrors,
    output int dropErrors,
    output int otherErrors
);

    int predCount = 0;
    int dropCount = 0;
    int otherCount = 0;
    // -1 once the sweep length has been checked
    int sweepCycles = 0;

    assign predErrors = predCount;
    assign dropErrors = dropCount;
    assign otherErrors = otherCount;

    task automatic valueError(string name, logic expected, logic actual);
        $display("error at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            sweepCycles = 0;
        end else if (initDone !== 1'b1) begin
            sweepCycles++;
        end else if (sweepCycles >= 0) begin
            if (sweepCycles != ghtPkg::INIT_CYCLES) begin
                $display("error at %0t: initDone low cycles expected %0d, got %0d",
                         $time, ghtPkg::INIT_CYCLES, sweepCycles);
                otherCount++;
            end
            sweepCycles = -1;
        end
        if (predValid !== expValid) begin
            valueError("predValid", expValid, predValid);
            predCount++;
        end
        if (expValid && pred !== expPred) begin
            valueError("pred", expPred, pred);
            predCount++;
        end
        if (dropped !== expDrop) begin
            valueError("dropped", expDrop, dropped);
            dropCount++;
        end
        if (modelDrop !== expDrop) begin
            $display("stimulus table and reference model disagree on dropped at %0t", $time);
            otherCount++;
        end
    end

endmodule

// File: tests/ghtTb.sv
// testbench top with clock, reset, stimulus table, reference table model
// and the watchdog
`timescale 1ns/1ps

module ghtTb;

    // one row of the stimulus table
    typedef struct packed {
        logic readEn;
        ghtPkg::addrT addr;
        ghtPkg::histT hist;
        ghtPkg::updateT upd0;
        ghtPkg::updateT upd1;
        logic dropExp;
    } stepT;

    // A C D in bank 0, B in bank 3, F in bank 4, G H J K in bank 2
    localparam ghtPkg::indexT IDX_A = 16'h1234;
    localparam ghtPkg::indexT IDX_B = 16'h5641;
    localparam ghtPkg::indexT IDX_C = 16'h9a02;
    localparam ghtPkg::indexT IDX_D = 16'h3c30;
    localparam ghtPkg::indexT IDX_F = 16'h2280;
    localparam ghtPkg::indexT IDX_G = 16'h4e40;
    localparam ghtPkg::indexT IDX_H = 16'h8c42;
    localparam ghtPkg::indexT IDX_J = 16'h1d46;
    localparam ghtPkg::indexT IDX_K = 16'h6b4a;

    logic clk = 1'b0;
    logic rst;
    logic readEn;
    ghtPkg::addrT addr;
    ghtPkg::histT hist;
    ghtPkg::updateT upd0;
    ghtPkg::updateT upd1;
    logic pred;
    logic predValid;
    logic dropped;
    logic initDone;
    logic expValid;
    logic expPred;
    logic expDrop;
    logic modelDrop;
    int predErrors;
    int dropErrors;
    int otherErrors;

    stepT steps[$];
    logic tableReady = 1'b0;
    int seed = 32'hf7a3;
    // reference model with one bit per full index and its deferral buffer
    logic refTable [65536];
    logic refBufValid;
    ghtPkg::updateT refBuf;

    always #2 clk = ~clk;

    ghtTop dut (.*);
    ghtChecker chk (.*);

    function automatic ghtPkg::updateT updateOf(ghtPkg::indexT idx, logic val);
        return ghtPkg::updateT'{1'b1, idx, val};
    endfunction

    function automatic ghtPkg::bankT bankNum(ghtPkg::indexT idx);
        return {idx[7:6], idx[0]};
    endfunction

    task automatic addStep(logic rd, ghtPkg::addrT a, ghtPkg::histT h,
                           ghtPkg::updateT u0, ghtPkg::updateT u1, logic dr);
        steps.push_back(stepT'{rd, a, h, u0, u1, dr});
    endtask

    // lookup whose addr and hist XOR to idx
    task automatic addLookup(ghtPkg::indexT idx, ghtPkg::histT h);
        addStep(1'b1, idx ^ h, h, '0, '0, 1'b0);
    endtask

    task automatic buildTable();
        ghtPkg::histT h;
        logic lastRow;
        // lookups and a same-bank pair of writes in the sweep leave no trace
        for (int i = 0; i < ghtPkg::INIT_CYCLES; i++) begin
            lastRow = (i == ghtPkg::INIT_CYCLES - 1);
            addStep(i[0], 16'(i * 16'h0123), 16'h5a5a,
                    ghtPkg::updateT'{lastRow, IDX_A, 1'b1},
                    ghtPkg::updateT'{lastRow, IDX_D, 1'b1}, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            h = 16'($random(seed));
            addLookup(16'($random(seed)), h);
        end
        addLookup(IDX_A, 16'h0000);
        addStep(1'b0, '0, '0, updateOf(IDX_A, 1'b1), '0, 1'b0);
        addLookup(IDX_A, 16'h0f0f);
        addStep(1'b0, '0, '0, updateOf(IDX_B, 1'b1), updateOf(IDX_F, 1'b1), 1'b0);
        addLookup(IDX_B, 16'h00ff);
        addLookup(IDX_F, 16'h3333);
        // deferred D reads old on this edge and new on the next
        addStep(1'b1, IDX_D, '0, updateOf(IDX_C, 1'b1), updateOf(IDX_D, 1'b1), 1'b0);
        addLookup(IDX_D, 16'h0000);
        addLookup(IDX_C, 16'h0000);
        // H deferred, J waits behind it, K is lost
        addStep(1'b0, '0, '0, updateOf(IDX_G, 1'b1), updateOf(IDX_H, 1'b1), 1'b0);
        addStep(1'b0, '0, '0, updateOf(IDX_J, 1'b1), updateOf(IDX_K, 1'b1), 1'b1);
        addLookup(IDX_H, 16'h0000);
        addLookup(IDX_J, 16'h0000);
        addLookup(IDX_K, 16'h0000);
        addLookup(IDX_G, 16'h0000);
        // buffer full with upd0 elsewhere, then upd0 blocked and upd1 free
        addStep(1'b0, '0, '0, updateOf(IDX_C, 1'b0), updateOf(IDX_D, 1'b0), 1'b0);
        addStep(1'b0, '0, '0, updateOf(IDX_B, 1'b0), updateOf(IDX_A, 1'b0), 1'b0);
        addStep(1'b1, IDX_A, '0, updateOf(IDX_C, 1'b1), updateOf(IDX_F, 1'b0), 1'b0);
        addLookup(IDX_C, 16'h0000);
        addLookup(IDX_F, 16'h0000);
        addLookup(IDX_D, 16'h0000);
        // back-to-back lookups with varied history
        for (int i = 0; i < 8; i++) begin
            h = 16'($random(seed));
            addLookup(i[0] ? IDX_J : IDX_B, h);
        end
    endtask

    // one row through the arbiter rule; drop tells whether upd1 is lost
    task automatic modelStep(stepT s, output logic drop);
        logic w0;
        logic w1;
        logic save0;
        logic save1;
        w0 = s.upd0.wen;
        w1 = s.upd1.wen;
        {save0, save1, drop} = '0;
        if (refBufValid) begin
            refTable[refBuf.idx] = refBuf.val;
        end
        if (refBufValid && w0 && bankNum(s.upd0.idx) == bankNum(refBuf.idx)) begin
            save0 = 1'b1;
            drop = w1 && bankNum(s.upd1.idx) == bankNum(refBuf.idx);
        end else begin
            if (w0) begin
                refTable[s.upd0.idx] = s.upd0.val;
            end
            save1 = w1 && ((w0 && bankNum(s.upd1.idx) == bankNum(s.upd0.idx)) ||
                    (refBufValid && bankNum(s.upd1.idx) == bankNum(refBuf.idx)));
        end
        if (w1 && !save1 && !drop) begin
            refTable[s.upd1.idx] = s.upd1.val;
        end
        refBufValid = save0 | save1;
        refBuf = save0 ? s.upd0 : (save1 ? s.upd1 : refBuf);
    endtask

    initial begin
        stepT s;
        logic drop;
        logic lookValid;
        logic lookPred;
        rst = 1'b1;
        {readEn, addr, hist, upd0, upd1} = '0;
        {expValid, expPred, expDrop, modelDrop} = '0;
        {refBufValid, refBuf, lookValid, lookPred} = '0;
        foreach (refTable[k]) begin
            refTable[k] = 1'b0;
        end
        buildTable();
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // row i is sampled on the next edge; one extra idle row at the end
        for (int i = 0; i <= steps.size(); i++) begin
            s = (i < steps.size()) ? steps[i] : stepT'(0);
            drop = 1'b0;
            if (i >= ghtPkg::INIT_CYCLES) begin
                modelStep(s, drop);
            end
            expValid <= lookValid;
            expPred <= lookPred;
            lookValid = s.readEn && i >= ghtPkg::INIT_CYCLES;
            lookPred = refTable[s.addr ^ s.hist];
            {readEn, addr, hist, upd0, upd1} <= {s.readEn, s.addr, s.hist, s.upd0, s.upd1};
            expDrop <= s.dropExp;
            modelDrop <= drop;
            @(posedge clk);
        end
        expValid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: pred %0d, dropped %0d, other %0d", predErrors, dropErrors, otherErrors);
        if (predErrors + dropErrors + otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (tableReady);
        #((steps.size() + 64) * 4);
        $display("timeout: the stimulus table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: flist.f
source/ghtPkg.sv
source/ghtInit.sv
source/ghtWriteArbiter.sv
source/ghtBank.sv
source/ghtLookup.sv
source/ghtTop.sv
tests/ghtChecker.sv
tests/ghtTb.sv

// File: run.sh
#!/bin/sh
# build and run the global history table testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ghtTb -f flist.f \
    -Mdir obj_dir -o ghtSim
./obj_dir/ghtSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
